//--- sources.f
+incdir+include
logic/cpu_pkg.sv
logic/mem_bus_if.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/exec_unit.sv
logic/writeback_unit.sv
logic/mem_arbiter.sv
logic/eightbit_core.sv
verification/eightbit_asserts.sv
verification/eightbit_checker.sv
verification/eightbit_tb.sv

//--- Bender.yml
package:
  name: eightbit_core

sources:
  - include_dirs:
      - include
    files:
      - logic/cpu_pkg.sv
      - logic/mem_bus_if.sv
      - logic/fetch_unit.sv
      - logic/decode_unit.sv
      - logic/exec_unit.sv
      - logic/writeback_unit.sv
      - logic/mem_arbiter.sv
      - logic/eightbit_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/eightbit_asserts.sv
      - verification/eightbit_checker.sv
      - verification/eightbit_tb.sv

//--- verification/eightbit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module eightbit_tb;

    import cpu_pkg::*;

    localparam int PERIOD       = 10;
    localparam int RUNS         = 8;
    localparam int INSTS        = 48;
    localparam int CYC_PER_INST = 40;
    localparam int RESET_CYCLES = 4;
    localparam int SETTLE       = 20;
    localparam int RUN_LIMIT    = INSTS * CYC_PER_INST;
    localparam int WATCHDOG     = RUNS * (RUN_LIMIT + RESET_CYCLES + SETTLE + 2);

    logic                   clk;
    logic                   rst;
    logic                   mem_req;
    logic                   we;
    logic                   mem_ready;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] wdata;
    logic [`CPU_DATA_W-1:0] rdata;

    logic [`CPU_DATA_W-1:0] mem [0:255];
    integer                 seed;
    int                     wait_left;
    int                     run_errors;
    int                     total;
    int                     run;

    eightbit_core uut (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .mem_ready (mem_ready)
    );

    eightbit_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .mem_ready (mem_ready)
    );

    always #(PERIOD / 2) clk = ~clk;

    // Memory answers after 0 to 3 wait cycles.
    always @(negedge clk) begin
        if (mem_ready) begin
            mem_ready = 1'b0; // Taken on the last rising edge.
            wait_left = -1;
        end
        if (mem_req !== 1'b1) begin
            wait_left = -1;
        end else begin
            if (wait_left < 0)
                wait_left = {$random(seed)} % 4;
            if (wait_left == 0) begin
                mem_ready = 1'b1;
                if (we)
                    mem[addr] = wdata;
                else
                    rdata = mem[addr];
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    task automatic load_program();
        inst_u       w;
        logic [31:0] r;
        int          k;
        int          j;
        for (k = 0; k < 256; k++)
            mem[k] = 8'(k * 37 + 11);
        for (k = 0; k < 64; k++)
            mem[`CPU_DATA_BASE + k] = 8'($random(seed));
        for (k = 0; k < INSTS; k++) begin
            r = $random(seed);
            case (r[2:0])
                3'd0:             w.fields.op = JMP;
                3'd1, 3'd2, 3'd3: w.fields.op = LOD;
                3'd4, 3'd5:       w.fields.op = STR;
                default:          w.fields.op = ADD;
            endcase
            w.fields.srcdst = r[3];
            w.fields.unused = r[10:4];
            w.fields.addr   = r[16:11];
            if (k == INSTS - 1) begin
                w.fields.op   = JMP; // Final slot jumps to itself.
                w.fields.addr = 6'(k);
            end else if (w.fields.op == JMP) begin
                j = k + 2 + int'(r[18:17]); // Skips up to four slots.
                w.fields.addr = 6'((j < INSTS) ? j : INSTS - 1);
            end
            mem[2 * k]     = w.bytes.hi;
            mem[2 * k + 1] = w.bytes.lo;
        end
        for (k = 0; k < 256; k++)
            u_checker.set_byte(k, mem[k]);
        u_checker.start_run();
    endtask

    task automatic wait_for_loop(input int run_idx);
        int cycles;
        cycles = 0;
        while ((u_checker.pending_count() != 0 || u_checker.loop_fetches < 3)
               && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= RUN_LIMIT) begin
            run_errors++;
            $display("run %0d did not reach its final jump loop within %0d cycles",
                     run_idx, RUN_LIMIT);
        end
        repeat (SETTLE) @(negedge clk);
        u_checker.finish_run(run_idx);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        mem_ready  = 1'b0;
        rdata      = '0;
        seed       = 32'h95f6_35bd;
        wait_left  = -1;
        run_errors = 0;
        for (run = 0; run < RUNS; run++) begin
            @(negedge clk);
            rst = 1'b0;
            @(negedge clk);
            load_program();
            repeat (RESET_CYCLES - 1) @(negedge clk);
            rst = 1'b1;
            wait_for_loop(run);
        end
        total = u_checker.mismatches + u_checker.failures + uut.u_asserts.failures + run_errors;
        $display("errors: %0d mismatches, %0d checker, %0d assertion, %0d run",
                 u_checker.mismatches, u_checker.failures, uut.u_asserts.failures, run_errors);
        if (total == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    initial begin
        #(WATCHDOG * PERIOD);
        $display("timeout: the runs did not finish within %0d cycles", WATCHDOG);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/eightbit_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module eightbit_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   mem_req,
    input logic                   we,
    input logic [`CPU_ADDR_W-1:0] addr,
    input logic [`CPU_DATA_W-1:0] wdata,
    input logic [`CPU_DATA_W-1:0] rdata,
    input logic                   mem_ready
);

    import cpu_pkg::*;

    logic [`CPU_DATA_W-1:0] image [0:255]; // Memory as loaded.
    logic [`CPU_DATA_W-1:0] dmem [0:255];
    bit                     on_path [0:255];
    logic [16:0]            expected [$];  // {we, addr, data} in program order.
    logic [`CPU_ADDR_W-1:0] last_pc;
    logic [`CPU_ADDR_W-1:0] hi_addr;
    bit                     first_fetch;
    int                     loop_fetches;
    int                     mismatches = 0;
    int                     failures = 0;

    task automatic set_byte(input int i, input logic [`CPU_DATA_W-1:0] value);
        image[i] = value;
    endtask

    function automatic int pending_count();
        return expected.size();
    endfunction

    function automatic string kind(input logic is_write);
        return is_write ? "store" : "load";
    endfunction

    // ISA model walked once over the loaded program.
    task automatic start_run();
        inst_u                  w;
        logic [`CPU_ADDR_W-1:0] pc;
        logic [`CPU_ADDR_W-1:0] daddr;
        logic [`CPU_DATA_W-1:0] ra;
        logic [`CPU_DATA_W-1:0] rb;
        logic [`CPU_DATA_W-1:0] val;
        bit                     done;
        int                     i;
        expected.delete();
        for (i = 0; i < 256; i++) begin
            dmem[i]    = image[i];
            on_path[i] = 1'b0;
        end
        pc   = '0;
        ra   = '0;
        rb   = '0;
        done = 1'b0;
        while (!done) begin
            w.bytes.hi  = image[pc];
            w.bytes.lo  = image[pc + 1];
            on_path[pc] = 1'b1;
            daddr = `CPU_DATA_BASE + `CPU_ADDR_W'(w.fields.addr);
            val   = w.fields.srcdst ? rb : ra;
            case (w.fields.op)
                JMP: begin
                    on_path[pc + 2] = 1'b1; // Fetch may run one slot ahead.
                    done    = ({1'b0, w.fields.addr, 1'b0} == pc);
                    last_pc = pc;
                    pc      = {1'b0, w.fields.addr, 1'b0};
                end
                LOD:     val = dmem[daddr];
                STR:     dmem[daddr] = val;
                default: val = ra + rb; // Wraps.
            endcase
            if (w.fields.op == LOD || w.fields.op == STR)
                expected.push_back({w.fields.op == STR, daddr, val});
            if (w.fields.op == LOD || w.fields.op == ADD) begin
                if (w.fields.srcdst)
                    rb = val;
                else
                    ra = val;
            end
            if (w.fields.op != JMP)
                pc = pc + 2;
        end
        first_fetch  = 1'b1;
        loop_fetches = 0;
        hi_addr      = '0;
    endtask

    task automatic check_data();
        logic [16:0] e;
        if (expected.size() == 0) begin
            failures++;
            $display("unexpected %s at address %h at time %0t", kind(we), addr, $time);
        end else begin
            e = expected.pop_front();
            if (we !== e[16] || addr !== e[15:8]) begin
                mismatches++;
                $display("mismatch at %0t: %s at %h, expected %s at %h", $time,
                         kind(we), addr, kind(e[16]), e[15:8]);
            end else if ((we ? wdata : rdata) !== e[7:0]) begin
                mismatches++;
                $display("mismatch at %0t: %s at %h carried %h, expected %h", $time,
                         kind(we), addr, we ? wdata : rdata, e[7:0]);
            end
        end
    endtask

    task automatic check_fetch();
        if (we) begin
            mismatches++;
            $display("mismatch at %0t: store to %h below the data area", $time, addr);
        end else if (!addr[0]) begin
            if (first_fetch && addr != 0) begin
                mismatches++;
                $display("mismatch at %0t: first fetch read %h, expected 00", $time, addr);
            end
            if (!on_path[addr]) begin
                mismatches++;
                $display("mismatch at %0t: fetch from %h off the executed path", $time, addr);
            end
            if (addr == last_pc)
                loop_fetches++;
            first_fetch = 1'b0;
            hi_addr     = addr;
        end else if (addr != `CPU_ADDR_W'(hi_addr + 1)) begin
            mismatches++;
            $display("mismatch at %0t: low byte read from %h, expected %h", $time,
                     addr, `CPU_ADDR_W'(hi_addr + 1));
        end
    endtask

    task automatic finish_run(input int run);
        if (expected.size() != 0) begin
            failures++;
            $display("run %0d ended with %0d expected loads or stores missing",
                     run, expected.size());
        end
    endtask

    always @(posedge clk) begin
        if (rst && mem_req && mem_ready) begin
            if (addr >= `CPU_DATA_BASE)
                check_data();
            else
                check_fetch();
        end
    end

endmodule

`default_nettype wire

//--- verification/eightbit_asserts.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module eightbit_asserts (
    input logic                   clk,
    input logic                   rst,
    input logic                   mem_req,
    input logic                   we,
    input logic [`CPU_ADDR_W-1:0] addr,
    input logic [`CPU_DATA_W-1:0] wdata,
    input logic                   mem_ready
);

    int failures = 0;

    we_needs_req: assert property (@(posedge clk) disable iff (!rst) we |-> mem_req)
        else begin
            $error("we high while mem_req is low");
            failures++;
        end

    // Request held until the memory answers.
    req_held: assert property (@(posedge clk) disable iff (!rst)
        (mem_req && !mem_ready) |=>
            (mem_req && $stable(addr) && $stable(we) && $stable(wdata)))
        else begin
            $error("request changed before mem_ready");
            failures++;
        end

    quiet_after_reset: assert property (@(posedge clk) $rose(rst) |-> (!mem_req && !we))
        else begin
            $error("memory request right after reset");
            failures++;
        end

endmodule

bind eightbit_core eightbit_asserts u_asserts (.*);

`default_nettype wire

//--- logic/eightbit_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module eightbit_core (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   mem_req,
    output logic                   we,
    output logic [`CPU_ADDR_W-1:0] addr,
    output logic [`CPU_DATA_W-1:0] wdata,
    input  logic [`CPU_DATA_W-1:0] rdata,
    input  logic                   mem_ready
);

    import cpu_pkg::*;

    mem_bus_if fetch_bus ();
    mem_bus_if exec_bus ();

    logic [`CPU_ADDR_W-1:0] pc;
    logic                   fetch_en, fetch_ready;
    inst_u                  fetch_inst;

    logic                   dec_en, dec_ready, dec_srcdst;
    inst_u                  dec_inst;
    opcode_e                dec_op;
    logic [`CPU_ADDR_W-1:0] dec_target, dec_data_addr;

    logic                   exec_en, exec_ready;
    exec_req_t              exec_q;
    wb_req_t                exec_result;

    logic                   wb_en, wb_ready;
    wb_req_t                wb_q;
    logic [`CPU_DATA_W-1:0] a, b;

    logic fetch_idle, dec_idle, exec_idle, wb_idle;

    assign fetch_idle = !fetch_en && !fetch_ready;
    assign dec_idle   = !dec_en && !dec_ready;
    assign exec_idle  = !exec_en && !exec_ready;
    assign wb_idle    = !wb_en && !wb_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc       <= '0;
            fetch_en <= 1'b0;
            dec_en   <= 1'b0;
            exec_en  <= 1'b0;
            wb_en    <= 1'b0;
        end else begin
            if (fetch_en && fetch_ready && dec_idle) begin
                dec_en   <= 1'b1;
                fetch_en <= 1'b0;
                pc       <= pc + `CPU_ADDR_W'(2);
            end else if (fetch_idle) begin
                fetch_en <= 1'b1;
            end

            if (dec_en && dec_ready) begin
                if (dec_op == JMP) begin
                    pc       <= dec_target; // Flush fetch and decode.
                    fetch_en <= 1'b0;
                    dec_en   <= 1'b0;
                end else if (exec_idle && wb_idle) begin
                    exec_en <= 1'b1;
                    dec_en  <= 1'b0;
                end
            end

            if (exec_en && exec_ready && wb_idle) begin
                wb_en   <= 1'b1;
                exec_en <= 1'b0;
            end

            if (wb_en && wb_ready)
                wb_en <= 1'b0;
        end
    end

    // Stage payloads.
    always_ff @(posedge clk) begin
        if (fetch_en && fetch_ready && dec_idle)
            dec_inst <= fetch_inst;
        if (dec_en && dec_ready && dec_op != JMP && exec_idle && wb_idle) begin
            exec_q.op     <= dec_op;
            exec_q.srcdst <= dec_srcdst;
            exec_q.addr   <= dec_data_addr;
            exec_q.val1   <= (dec_op == STR && dec_srcdst) ? b : a;
            exec_q.val2   <= b;
        end
        if (exec_en && exec_ready && wb_idle)
            wb_q <= exec_result;
    end

    fetch_unit u_fetch (
        .clk   (clk),
        .rst   (rst),
        .en    (fetch_en),
        .pc    (pc),
        .bus   (fetch_bus),
        .inst  (fetch_inst),
        .ready (fetch_ready)
    );

    decode_unit u_decode (
        .clk       (clk),
        .rst       (rst),
        .en        (dec_en),
        .inst      (dec_inst),
        .op        (dec_op),
        .srcdst    (dec_srcdst),
        .target    (dec_target),
        .data_addr (dec_data_addr),
        .ready     (dec_ready)
    );

    exec_unit u_exec (
        .clk    (clk),
        .rst    (rst),
        .en     (exec_en),
        .req    (exec_q),
        .bus    (exec_bus),
        .result (exec_result),
        .ready  (exec_ready)
    );

    writeback_unit u_writeback (
        .clk   (clk),
        .rst   (rst),
        .en    (wb_en),
        .wb    (wb_q),
        .a     (a),
        .b     (b),
        .ready (wb_ready)
    );

    mem_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .fetch_bus (fetch_bus),
        .exec_bus  (exec_bus),
        .mem_req   (mem_req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .mem_ready (mem_ready)
    );

endmodule

`default_nettype wire

//--- logic/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    mem_bus_if.arbiter             fetch_bus,
    mem_bus_if.arbiter             exec_bus,
    output logic                   mem_req,
    output logic                   we,
    output logic [`CPU_ADDR_W-1:0] addr,
    output logic [`CPU_DATA_W-1:0] wdata,
    input  logic [`CPU_DATA_W-1:0] rdata,
    input  logic                   mem_ready
);

    logic busy;       // A granted transaction is still open.
    logic owner_exec;
    logic sel_exec;

    // Execute wins a free bus.
    assign sel_exec = busy ? owner_exec : exec_bus.req;

    assign mem_req = sel_exec ? exec_bus.req : fetch_bus.req;
    assign we      = sel_exec ? exec_bus.we : fetch_bus.we;
    assign addr    = sel_exec ? exec_bus.addr : fetch_bus.addr;
    assign wdata   = sel_exec ? exec_bus.wdata : fetch_bus.wdata;

    // Ready and data go straight through to the owner.
    assign exec_bus.ready  = mem_req && mem_ready && sel_exec;
    assign fetch_bus.ready = mem_req && mem_ready && !sel_exec;
    assign exec_bus.rdata  = rdata;
    assign fetch_bus.rdata = rdata;

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy       <= 1'b0;
            owner_exec <= 1'b0;
        end else if (mem_req && mem_ready) begin
            busy <= 1'b0;
        end else if (mem_req && !busy) begin
            busy       <= 1'b1; // Lock until ready.
            owner_exec <= sel_exec;
        end
    end

endmodule

`default_nettype wire

//--- logic/writeback_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module writeback_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  cpu_pkg::wb_req_t       wb,
    output logic [`CPU_DATA_W-1:0] a,
    output logic [`CPU_DATA_W-1:0] b,
    output logic                   ready
);

    import cpu_pkg::*;

    logic commit;

    // Commit once, on the edge that raises ready.
    assign commit = en && !ready && (wb.op == LOD || wb.op == ADD);

    always_ff @(posedge clk) begin
        if (!rst) begin
            a     <= '0;
            b     <= '0;
            ready <= 1'b0;
        end else begin
            ready <= en;
            if (commit && wb.srcdst)
                b <= wb.result;
            else if (commit)
                a <= wb.result;
        end
    end

endmodule

`default_nettype wire

//--- logic/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module exec_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  cpu_pkg::exec_req_t req,
    mem_bus_if.requester       bus,
    output cpu_pkg::wb_req_t   result,
    output logic               ready
);

    import cpu_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_MEM, S_DONE} state_e;

    state_e state;

    // The core holds req steady while en is high.
    assign bus.req   = (state == S_MEM);
    assign bus.we    = (state == S_MEM) && (req.op == STR);
    assign bus.addr  = req.addr;
    assign bus.wdata = req.val1;
    assign ready     = (state == S_DONE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (en)
                        state <= (req.op == LOD || req.op == STR) ? S_MEM : S_DONE;
                end
                S_MEM:  if (bus.ready) state <= S_DONE;
                S_DONE: if (!en) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && en) begin
            result.op     <= req.op;
            result.srcdst <= req.srcdst;
            if (req.op == ADD)
                result.result <= req.val1 + req.val2; // Wraps mod 256.
            else
                result.result <= req.val1;
        end
        if (state == S_MEM && bus.ready && req.op == LOD)
            result.result <= bus.rdata;
    end

endmodule

`default_nettype wire

//--- logic/decode_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module decode_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  cpu_pkg::inst_u         inst,
    output cpu_pkg::opcode_e       op,
    output logic                   srcdst,
    output logic [`CPU_ADDR_W-1:0] target,
    output logic [`CPU_ADDR_W-1:0] data_addr,
    output logic                   ready
);

    // Ready follows en by one cycle.
    always_ff @(posedge clk) begin
        if (!rst)
            ready <= 1'b0;
        else
            ready <= en;
    end

    always_ff @(posedge clk) begin
        if (en) begin
            op        <= inst.fields.op;
            srcdst    <= inst.fields.srcdst;
            target    <= `CPU_ADDR_W'({inst.fields.addr, 1'b0}); // Byte address of slot.
            data_addr <= `CPU_DATA_BASE + `CPU_ADDR_W'(inst.fields.addr);
        end
    end

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  logic [`CPU_ADDR_W-1:0] pc,
    mem_bus_if.requester           bus,
    output cpu_pkg::inst_u         inst,
    output logic                   ready
);

    typedef enum logic [1:0] {S_IDLE, S_RD_HI, S_RD_LO, S_DONE} state_e;

    state_e                 state;
    logic [`CPU_ADDR_W-1:0] addr_q;
    logic                   stale; // En dropped while a read was open.

    assign bus.req   = (state == S_RD_HI) || (state == S_RD_LO);
    assign bus.we    = 1'b0;
    assign bus.addr  = addr_q;
    assign bus.wdata = '0;
    assign ready     = (state == S_DONE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= S_IDLE;
            stale <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (en) state <= S_RD_HI;
                S_RD_HI, S_RD_LO: begin
                    if (bus.ready) begin
                        stale <= 1'b0;
                        if (!en || stale)
                            state <= S_IDLE; // Flushed word is dropped.
                        else
                            state <= (state == S_RD_HI) ? S_RD_LO : S_DONE;
                    end else if (!en) begin
                        stale <= 1'b1;
                    end
                end
                S_DONE: if (!en) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Address and instruction bytes.
    always_ff @(posedge clk) begin
        if (state == S_IDLE && en)
            addr_q <= pc;
        if (bus.ready && state == S_RD_HI) begin
            inst.bytes.hi <= bus.rdata;
            addr_q        <= addr_q + 1'b1;
        end
        if (bus.ready && state == S_RD_LO)
            inst.bytes.lo <= bus.rdata;
    end

endmodule

`default_nettype wire

//--- logic/mem_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

// One requester's view of the shared memory port.
interface mem_bus_if;

    logic                   req;
    logic                   we;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] wdata;
    logic [`CPU_DATA_W-1:0] rdata;
    logic                   ready; // High for one cycle with rdata valid.

    modport requester (
        output req, we, addr, wdata,
        input  rdata, ready
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, ready
    );

endinterface

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

    typedef enum logic [1:0] {
        JMP = 2'b00,
        LOD = 2'b01,
        STR = 2'b10,
        ADD = 2'b11
    } opcode_e;

    typedef struct packed {
        opcode_e                 op;
        logic                    srcdst; // Set selects b.
        logic [`CPU_INST_W-10:0] unused;
        logic [5:0]              addr;
    } inst_fields_t;

    typedef struct packed {
        logic [`CPU_DATA_W-1:0] hi; // Byte at the even address.
        logic [`CPU_DATA_W-1:0] lo;
    } inst_bytes_t;

    // Fetch fills bytes, decode reads fields.
    typedef union packed {
        inst_fields_t fields;
        inst_bytes_t  bytes;
    } inst_u;

    typedef struct packed {
        opcode_e                op;
        logic                   srcdst;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] val1;
        logic [`CPU_DATA_W-1:0] val2;
    } exec_req_t;

    typedef struct packed {
        opcode_e                op;
        logic                   srcdst;
        logic [`CPU_DATA_W-1:0] result;
    } wb_req_t;

endpackage

`default_nettype wire

//--- include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Register and bus data width.
`define CPU_DATA_W 8

// Byte address width.
`define CPU_ADDR_W 8

// Two big-endian bytes per instruction.
`define CPU_INST_W 16

// Load and store addresses start here.
`define CPU_DATA_BASE 8'h80

`endif
